// ==== filelist.f ====
src/rv_pkg.sv
src/id_stage.sv
src/regfile.sv
src/exe_stage.sv
src/core_ctrl.sv
src/perf_counter.sv
src/core_top.sv
verification/core_assert.sv
verification/core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the core testbench with verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module core_tb -o core_sim
./obj_dir/core_sim 2>&1 | tee sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "simulation failed"
  exit 1
fi
echo "simulation passed"

// ==== src/core_ctrl.sv ====
// core_ctrl steps each instruction through the fsm and owns the pc and instruction registers
`timescale 1ns/1ns

module core_ctrl #(
  parameter rv_pkg::xlen_t reset_pc = 64'h8000_0000
) (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::inst_t imem_rdata,
  input  rv_pkg::xlen_t next_pc,
  input  logic          mem_ren,
  input  logic          mem_wen,
  input  logic          rd_wen,
  input  logic          is_halt,
  output rv_pkg::inst_t inst,
  output rv_pkg::xlen_t pc,
  output rv_pkg::xlen_t imem_addr,
  output logic          imem_en,
  output logic          dmem_ren,
  output logic          dmem_wen,
  output logic          ex_en,
  output logic          wb_load,
  output logic          reg_wen,
  output logic          retire,
  output logic          halted
);
  import rv_pkg::*;

  core_state_t state;

  // imem_en is registered so it stays low through reset
  // st_fetch with imem_en low only happens on the first cycle out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= st_fetch;
      imem_en <= 1'b0;
      pc      <= reset_pc;
    end else begin
      case (state)
        st_fetch: begin
          if (imem_en) begin
            imem_en <= 1'b0;
            state   <= st_decode;
          end else begin
            imem_en <= 1'b1;
          end
        end
        st_decode:    state <= st_execute;
        st_execute:   state <= (mem_ren || mem_wen) ? st_mem : st_writeback;
        st_mem:       state <= st_writeback;
        st_writeback: begin
          pc <= next_pc;
          if (is_halt) begin
            state <= st_halt;
          end else begin
            // next fetch strobe lines up with the return to st_fetch
            state   <= st_fetch;
            imem_en <= 1'b1;
          end
        end
        st_halt:      state <= st_halt;
        default:      state <= st_fetch;
      endcase
    end
  end

  // fetched word is valid the cycle after imem_en
  always_ff @(posedge clk) begin
    if (state == st_decode) begin
      inst <= imem_rdata;
    end
  end

  assign imem_addr = pc;

  // single-cycle strobes derived from the state
  assign dmem_ren = (state == st_mem) && mem_ren;
  assign dmem_wen = (state == st_mem) && mem_wen;
  assign ex_en    = (state == st_execute);
  assign wb_load  = (state == st_writeback) && mem_ren;
  assign reg_wen  = (state == st_writeback) && rd_wen;
  assign retire   = (state == st_writeback);
  assign halted   = (state == st_halt);

endmodule

// ==== src/core_top.sv ====
// core_top wires the rv64i multicycle core to its instruction and data memory ports
`timescale 1ns/1ns

module core_top #(
  parameter rv_pkg::xlen_t reset_pc      = 64'h8000_0000,
  parameter int            counter_width = 64
) (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::inst_t imem_rdata,
  input  rv_pkg::xlen_t dmem_rdata,
  output logic          imem_en,
  output logic          dmem_ren,
  output logic          dmem_wen,
  output logic          halted,
  output rv_pkg::xlen_t imem_addr,
  output rv_pkg::xlen_t dmem_addr,
  output rv_pkg::xlen_t dmem_wdata
);
  import rv_pkg::*;

  // controller side
  inst_t      inst;
  xlen_t      pc;
  xlen_t      next_pc;
  logic       ex_en;
  logic       wb_load;
  logic       reg_wen;
  logic       retire;

  // decode side
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  logic       rd_wen;
  logic       mem_ren;
  logic       mem_wen;
  logic       is_branch;
  logic       is_jalr;
  logic       is_halt;
  xlen_t      op1;
  xlen_t      op2;
  xlen_t      t1;
  logic [1:0] alu_sel;
  csr_addr_t  csr_addr;
  xlen_t      csr_rdata;

  // register file and writeback
  xlen_t      rs1_data;
  xlen_t      rs2_data;
  xlen_t      result;

  core_ctrl #(
    .reset_pc (reset_pc)
  ) u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .imem_rdata (imem_rdata),
    .next_pc    (next_pc),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .rd_wen     (rd_wen),
    .is_halt    (is_halt),
    .inst       (inst),
    .pc         (pc),
    .imem_addr  (imem_addr),
    .imem_en    (imem_en),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .ex_en      (ex_en),
    .wb_load    (wb_load),
    .reg_wen    (reg_wen),
    .retire     (retire),
    .halted     (halted)
  );

  perf_counter #(
    .counter_width (counter_width)
  ) u_perf (
    .clk       (clk),
    .rst       (rst),
    .retire    (retire),
    .csr_addr  (csr_addr),
    .csr_rdata (csr_rdata)
  );

  // itype and csr_ren are only consumed inside decode
  id_stage u_id (
    .inst      (inst),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .pc        (pc),
    .csr_rdata (csr_rdata),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .rd_wen    (rd_wen),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .is_branch (is_branch),
    .is_jalr   (is_jalr),
    .is_halt   (is_halt),
    .mem_addr  (dmem_addr),
    .mem_wdata (dmem_wdata),
    .op1       (op1),
    .op2       (op2),
    .t1        (t1),
    .csr_addr  (csr_addr),
    .csr_ren   (),
    .itype     (),
    .alu_sel   (alu_sel)
  );

  regfile u_rf (
    .clk    (clk),
    .rst    (rst),
    .wen    (reg_wen),
    .waddr  (rd),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .wdata  (result),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data)
  );

  exe_stage u_exe (
    .clk        (clk),
    .rst        (rst),
    .ex_en      (ex_en),
    .wb_load    (wb_load),
    .op1        (op1),
    .op2        (op2),
    .t1         (t1),
    .pc         (pc),
    .dmem_rdata (dmem_rdata),
    .alu_sel    (alu_sel),
    .is_branch  (is_branch),
    .is_jalr    (is_jalr),
    .result     (result),
    .next_pc    (next_pc)
  );

endmodule

// ==== src/exe_stage.sv ====
// exe_stage runs the alu, resolves the next pc and selects the writeback data
`timescale 1ns/1ns

module exe_stage (
  input  logic          clk,
  input  logic          rst,
  input  logic          ex_en,
  input  logic          wb_load,
  input  rv_pkg::xlen_t op1,
  input  rv_pkg::xlen_t op2,
  input  rv_pkg::xlen_t t1,
  input  rv_pkg::xlen_t pc,
  input  rv_pkg::xlen_t dmem_rdata,
  input  logic [1:0]    alu_sel,
  input  logic          is_branch,
  input  logic          is_jalr,
  output rv_pkg::xlen_t result,
  output rv_pkg::xlen_t next_pc
);
  import rv_pkg::*;

  xlen_t alu_out;
  xlen_t target;
  xlen_t result_q;
  logic  taken;

  // add, logical shifts, or pass op1 through for lui, links and csr reads
  always_comb begin
    case (alu_sel)
      alu_add:  alu_out = op1 + op2;
      alu_sll:  alu_out = op1 << op2[5:0];
      alu_srl:  alu_out = op1 >> op2[5:0];
      default:  alu_out = op1;
    endcase
  end

  // beq compares the two register operands
  assign taken = is_branch && (op1 == op2);

  // jalr clears bit 0, other non-branches already have t1 as their target
  always_comb begin
    if (is_jalr) begin
      target = {t1[63:1], 1'b0};
    end else if (is_branch) begin
      target = taken ? t1 : pc + 64'd4;
    end else begin
      target = t1;
    end
  end

  // both registered in the execute cycle, held through mem and writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      result_q <= '0;
      next_pc  <= '0;
    end else if (ex_en) begin
      result_q <= alu_out;
      next_pc  <= target;
    end
  end

  // load data arrives the cycle after the read strobe, i.e. in writeback
  assign result = wb_load ? dmem_rdata : result_q;

endmodule

// ==== src/id_stage.sv ====
// id_stage decodes the latched instruction into operands, targets and control strobes
`timescale 1ns/1ns

module id_stage (
  input  rv_pkg::inst_t     inst,
  input  rv_pkg::xlen_t     rs1_data,
  input  rv_pkg::xlen_t     rs2_data,
  input  rv_pkg::xlen_t     pc,
  input  rv_pkg::xlen_t     csr_rdata,
  output rv_pkg::reg_idx_t  rs1,
  output rv_pkg::reg_idx_t  rs2,
  output rv_pkg::reg_idx_t  rd,
  output logic              rd_wen,
  output logic              mem_ren,
  output logic              mem_wen,
  output logic              is_branch,
  output logic              is_jalr,
  output logic              is_halt,
  output rv_pkg::xlen_t     mem_addr,
  output rv_pkg::xlen_t     mem_wdata,
  output rv_pkg::xlen_t     op1,
  output rv_pkg::xlen_t     op2,
  output rv_pkg::xlen_t     t1,
  output rv_pkg::csr_addr_t csr_addr,
  output logic              csr_ren,
  output rv_pkg::itype_t    itype,
  output logic [1:0]        alu_sel
);
  import rv_pkg::*;

  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] shamt;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  xlen_t      imm;
  xlen_t      pc_plus4;

  // instruction fields
  assign opcode = inst[6:2];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rd     = inst[11:7];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  // rv64 shifts take six bits of shamt
  assign shamt  = inst[25:20];

  // sign-extended immediates per format
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  assign pc_plus4 = pc + 64'd4;

  // format class from the major opcode
  always_comb begin
    case (opcode)
      opcode_lui, opcode_auipc:                  itype = itype_u;
      opcode_jal:                                itype = itype_j;
      opcode_jalr, opcode_load, opcode_op_imm:   itype = itype_i;
      opcode_system:                             itype = itype_i;
      opcode_beq:                                itype = itype_b;
      opcode_store:                              itype = itype_s;
      opcode_op:                                 itype = itype_r;
      default:                                   itype = itype_none;
    endcase
  end

  // r-type and unknown formats carry no immediate
  always_comb begin
    case (itype)
      itype_i: imm = imm_i;
      itype_s: imm = imm_s;
      itype_b: imm = imm_b;
      itype_u: imm = imm_u;
      itype_j: imm = imm_j;
      default: imm = '0;
    endcase
  end

  // operand select and controls, anything unrecognised falls through as a nop
  always_comb begin
    rd_wen    = 1'b0;
    mem_ren   = 1'b0;
    mem_wen   = 1'b0;
    is_branch = 1'b0;
    csr_ren   = 1'b0;
    alu_sel   = alu_add;
    op1       = rs1_data;
    op2       = imm;
    // default target is the next sequential pc
    t1        = pc_plus4;
    case (opcode)
      opcode_lui: begin
        rd_wen  = 1'b1;
        op1     = imm;
        alu_sel = alu_pass;
      end
      opcode_auipc: begin
        rd_wen = 1'b1;
        op1    = pc;
      end
      opcode_jal: begin
        // link value rides on op1
        rd_wen  = 1'b1;
        op1     = pc_plus4;
        alu_sel = alu_pass;
        t1      = pc + imm;
      end
      opcode_jalr: begin
        rd_wen  = 1'b1;
        op1     = pc_plus4;
        alu_sel = alu_pass;
        t1      = rs1_data + imm;
      end
      opcode_beq: begin
        if (funct3 == funct3_beq) begin
          is_branch = 1'b1;
          op2       = rs2_data;
          t1        = pc + imm;
        end
      end
      opcode_load: begin
        if (funct3 == funct3_ld) begin
          mem_ren = 1'b1;
          rd_wen  = 1'b1;
        end
      end
      opcode_store: begin
        mem_wen = (funct3 == funct3_sd);
      end
      opcode_op_imm: begin
        if (funct3 == funct3_add) begin
          rd_wen = 1'b1;
        end else if (funct3 == funct3_slli && funct7[6:1] == 6'd0) begin
          rd_wen  = 1'b1;
          op2     = {58'd0, shamt};
          alu_sel = alu_sll;
        end else if (funct3 == funct3_srli && funct7[6:1] == 6'd0) begin
          rd_wen  = 1'b1;
          op2     = {58'd0, shamt};
          alu_sel = alu_srl;
        end
      end
      opcode_op: begin
        if (funct3 == funct3_add && funct7 == 7'd0) begin
          rd_wen = 1'b1;
          op2    = rs2_data;
        end
      end
      opcode_system: begin
        // only the read-only csrrs form, rs1 = x0
        if (funct3 == funct3_csrrs && rs1 == 5'd0) begin
          csr_ren = 1'b1;
          rd_wen  = 1'b1;
          op1     = csr_rdata;
          alu_sel = alu_pass;
        end
      end
      default: begin
      end
    endcase
  end

  assign is_jalr = (opcode == opcode_jalr);
  assign is_halt = (inst == inst_ebreak);

  // ld/sd address, the store data is always rs2
  assign mem_addr  = rs1_data + imm;
  assign mem_wdata = rs2_data;

  assign csr_addr = csr_ren ? inst[31:20] : '0;

endmodule

// ==== src/perf_counter.sv ====
// perf_counter keeps the mcycle and minstret counters and serves csr reads of them
`timescale 1ns/1ns

module perf_counter #(
  parameter int counter_width = 64
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              retire,
  input  rv_pkg::csr_addr_t csr_addr,
  output rv_pkg::xlen_t     csr_rdata
);
  import rv_pkg::*;

  logic [counter_width-1:0] mcycle;
  logic [counter_width-1:0] minstret;

  // mcycle free-runs, minstret follows retire pulses
  always_ff @(posedge clk) begin
    if (rst) begin
      mcycle   <= '0;
      minstret <= '0;
    end else begin
      mcycle <= mcycle + 1'b1;
      if (retire) begin
        minstret <= minstret + 1'b1;
      end
    end
  end

  // unknown csr addresses read as zero
  always_comb begin
    case (csr_addr)
      csr_mcycle:   csr_rdata = xlen_t'(mcycle);
      csr_minstret: csr_rdata = xlen_t'(minstret);
      default:      csr_rdata = '0;
    endcase
  end

endmodule

// ==== src/regfile.sv ====
// regfile holds the 32 integer registers with two read ports and one write port
`timescale 1ns/1ns

module regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             wen,
  input  rv_pkg::reg_idx_t waddr,
  input  rv_pkg::reg_idx_t raddr1,
  input  rv_pkg::reg_idx_t raddr2,
  input  rv_pkg::xlen_t    wdata,
  output rv_pkg::xlen_t    rdata1,
  output rv_pkg::xlen_t    rdata2
);
  import rv_pkg::*;

  xlen_t regs [32];

  // single write port, x0 is never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous reads, x0 hardwired to zero
  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== src/rv_pkg.sv ====
// rv64i core package with widths, instruction encodings, csr addresses and fsm states
package rv_pkg;

  // widths that carry meaning across the core
  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [2:0]  itype_t;

  // instruction format classes
  localparam itype_t itype_none = 3'd0;
  localparam itype_t itype_r    = 3'd1;
  localparam itype_t itype_i    = 3'd2;
  localparam itype_t itype_s    = 3'd3;
  localparam itype_t itype_b    = 3'd4;
  localparam itype_t itype_u    = 3'd5;
  localparam itype_t itype_j    = 3'd6;

  // controller sequence, one instruction at a time
  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_execute,
    st_mem,
    st_writeback,
    st_halt
  } core_state_t;

  // major opcodes, inst[6:2] (the low two bits are always 2'b11)
  localparam logic [4:0] opcode_lui    = 5'b01101;
  localparam logic [4:0] opcode_auipc  = 5'b00101;
  localparam logic [4:0] opcode_jal    = 5'b11011;
  localparam logic [4:0] opcode_jalr   = 5'b11001;
  localparam logic [4:0] opcode_beq    = 5'b11000;
  localparam logic [4:0] opcode_load   = 5'b00000;
  localparam logic [4:0] opcode_store  = 5'b01000;
  localparam logic [4:0] opcode_op_imm = 5'b00100;
  localparam logic [4:0] opcode_op     = 5'b01100;
  localparam logic [4:0] opcode_system = 5'b11100;

  // funct3 codes for the supported subset
  localparam logic [2:0] funct3_add   = 3'b000;
  localparam logic [2:0] funct3_beq   = 3'b000;
  localparam logic [2:0] funct3_slli  = 3'b001;
  localparam logic [2:0] funct3_srli  = 3'b101;
  localparam logic [2:0] funct3_csrrs = 3'b010;
  localparam logic [2:0] funct3_ld    = 3'b011;
  localparam logic [2:0] funct3_sd    = 3'b011;

  // alu operation select
  localparam logic [1:0] alu_add  = 2'd0;
  localparam logic [1:0] alu_sll  = 2'd1;
  localparam logic [1:0] alu_srl  = 2'd2;
  localparam logic [1:0] alu_pass = 2'd3;

  // counter csrs and the halt encoding
  localparam csr_addr_t csr_mcycle   = 12'hB00;
  localparam csr_addr_t csr_minstret = 12'hB02;
  localparam inst_t     inst_ebreak  = 32'h0010_0073;

endpackage

// ==== verification/core_assert.sv ====
// core_assert checks the fetch and data strobe protocol of the core controller
`timescale 1ns/1ns

module core_assert (
  input logic clk,
  input logic rst,
  input logic imem_en,
  input logic dmem_ren,
  input logic dmem_wen,
  input logic halted
);

  logic [3:0] gap;
  logic       fetched;

  // cycles since the last fetch strobe, saturating
  always_ff @(posedge clk) begin
    if (rst) begin
      gap     <= '0;
      fetched <= 1'b0;
    end else if (imem_en) begin
      gap     <= 4'd1;
      fetched <= 1'b1;
    end else if (gap != 4'hf) begin
      gap <= gap + 4'd1;
    end
  end

  fetch_pulse: assert property (@(posedge clk) disable iff (rst) imem_en |=> !imem_en)
    else $error("imem_en held high for more than one cycle");

  no_rw_overlap: assert property (@(posedge clk) disable iff (rst) !(dmem_ren && dmem_wen))
    else $error("dmem_ren and dmem_wen high together");

  quiet_halt: assert property (@(posedge clk) disable iff (rst)
    halted |-> !imem_en && !dmem_ren && !dmem_wen)
    else $error("strobe issued while halted");

  // 4 cycles per instruction, 5 with a memory access
  fetch_gap: assert property (@(posedge clk) disable iff (rst)
    imem_en && fetched |-> gap == 4'd4 || gap == 4'd5)
    else $error("fetches not 4 or 5 cycles apart");

endmodule

// ==== verification/core_tb.sv ====
// core_tb runs directed and random programs on the rv64i core and checks them against an isa model
`timescale 1ns/1ns

module core_tb;
  import rv_pkg::*;

  localparam xlen_t reset_pc = 64'h8000_0000;

  logic  clk = 1'b0;
  logic  rst = 1'b1;
  inst_t imem_rdata = '0;
  xlen_t dmem_rdata = '0;
  logic  imem_en;
  logic  dmem_ren;
  logic  dmem_wen;
  logic  halted;
  xlen_t imem_addr;
  xlen_t dmem_addr;
  xlen_t dmem_wdata;

  // memory models, instruction side is word indexed from reset_pc
  inst_t      imem [256];
  xlen_t      dmem [xlen_t];
  logic       imem_pend = 1'b0;
  logic [7:0] imem_idx = '0;
  logic       dmem_pend = 1'b0;
  xlen_t      dmem_raddr = '0;

  // isa model of the program being built
  xlen_t x [32];
  xlen_t shmem [xlen_t];
  int    wp;
  int    n_ret;
  int    n_mem;
  string test_name;

  // expected fetch addresses and stores, in program order
  xlen_t fetch_q [$];
  xlen_t exp_addr [$];
  xlen_t exp_data [$];

  logic [31:0] seed = 32'h53c0_64ba;
  int          cycles = 0;
  int          limit = 200;

  core_top #(
    .reset_pc      (reset_pc),
    .counter_width (64)
  ) u_dut (
    .clk        (clk),
    .rst        (rst),
    .imem_rdata (imem_rdata),
    .dmem_rdata (dmem_rdata),
    .imem_en    (imem_en),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .halted     (halted),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata)
  );

  bind core_ctrl core_assert u_assert (
    .clk      (clk),
    .rst      (rst),
    .imem_en  (imem_en),
    .dmem_ren (dmem_ren),
    .dmem_wen (dmem_wen),
    .halted   (halted)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  // run limit grows with every program loaded
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      stop_with_error($sformatf("timeout after %0d cycles, core never halted", cycles));
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s ^ (s << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic int rand_field(input int bits);
    seed = xorshift(seed);
    return int'(seed & 32'((1 << bits) - 1));
  endfunction

  function automatic int rand_imm12();
    return rand_field(12) - 2048;
  endfunction

  // unwritten data words read back as a function of their address
  function automatic xlen_t fill_word(input xlen_t a);
    return a ^ 64'h9e37_79b9_7f4a_7c15;
  endfunction

  function automatic inst_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                  input int rd, input logic [6:0] opc);
    return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic inst_t enc_s(input int imm, input int rs2, input int rs1);
    logic [11:0] i;
    i = 12'(imm);
    return {i[11:5], 5'(rs2), 5'(rs1), 3'b011, i[4:0], 7'h23};
  endfunction

  function automatic inst_t enc_b(input int off, input int rs2, input int rs1);
    logic [12:0] b;
    b = 13'(off);
    return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'b000, b[4:1], b[11], 7'h63};
  endfunction

  function automatic inst_t enc_j(input int off, input int rd);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'h6f};
  endfunction

  function automatic xlen_t rv(input int r);
    return x[r[4:0]];
  endfunction

  function automatic xlen_t pc_now();
    return reset_pc + 64'(4 * wp);
  endfunction

  task automatic set_reg(input int rd, input xlen_t v);
    if (rd != 0) begin
      x[rd[4:0]] = v;
    end
  endtask

  // an executed instruction, its address joins the expected fetch order
  task automatic put(input inst_t w);
    fetch_q.push_back(pc_now());
    imem[wp[7:0]] = w;
    wp++;
    n_ret++;
  endtask

  // a word the control flow jumps over
  task automatic skip_word(input inst_t w);
    imem[wp[7:0]] = w;
    wp++;
  endtask

  task automatic lui(input int rd, input int imm20);
    logic [31:0] u;
    u = 32'(imm20) << 12;
    set_reg(rd, {{32{u[31]}}, u});
    put({20'(imm20), 5'(rd), 7'h37});
  endtask

  task automatic auipc(input int rd, input int imm20);
    logic [31:0] u;
    u = 32'(imm20) << 12;
    set_reg(rd, pc_now() + {{32{u[31]}}, u});
    put({20'(imm20), 5'(rd), 7'h17});
  endtask

  task automatic addi(input int rd, input int rs1, input int imm);
    set_reg(rd, rv(rs1) + 64'(imm));
    put(enc_i(imm, rs1, 3'b000, rd, 7'h13));
  endtask

  task automatic slli(input int rd, input int rs1, input int sh);
    set_reg(rd, rv(rs1) << sh);
    put(enc_i(sh, rs1, 3'b001, rd, 7'h13));
  endtask

  task automatic srli(input int rd, input int rs1, input int sh);
    set_reg(rd, rv(rs1) >> sh);
    put(enc_i(sh, rs1, 3'b101, rd, 7'h13));
  endtask

  task automatic add(input int rd, input int rs1, input int rs2);
    set_reg(rd, rv(rs1) + rv(rs2));
    put({7'd0, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'h33});
  endtask

  // caller lays out the words so the next executed one sits at the target
  task automatic beq(input int rs1, input int rs2, input int off);
    put(enc_b(off, rs2, rs1));
  endtask

  task automatic jal(input int rd, input int off);
    set_reg(rd, pc_now() + 64'd4);
    put(enc_j(off, rd));
  endtask

  task automatic jalr(input int rd, input int rs1, input int imm);
    set_reg(rd, pc_now() + 64'd4);
    put(enc_i(imm, rs1, 3'b000, rd, 7'h67));
  endtask

  task automatic ld(input int rd, input int rs1, input int imm);
    xlen_t a;
    a = rv(rs1) + 64'(imm);
    set_reg(rd, shmem.exists(a) ? shmem[a] : fill_word(a));
    n_mem++;
    put(enc_i(imm, rs1, 3'b011, rd, 7'h03));
  endtask

  task automatic sd(input int rs2, input int rs1, input int imm);
    xlen_t a;
    a = rv(rs1) + 64'(imm);
    shmem[a] = rv(rs2);
    exp_addr.push_back(a);
    exp_data.push_back(rv(rs2));
    n_mem++;
    put(enc_s(imm, rs2, rs1));
  endtask

  // first fetch sees mcycle 1 and execute comes two cycles after fetch
  task automatic csrr(input int rd, input int csr);
    if (csr == 'hB02) begin
      set_reg(rd, 64'(n_ret));
    end else begin
      set_reg(rd, 64'(3 + 4 * (n_ret - n_mem) + 5 * n_mem));
    end
    put(enc_i(csr, 0, 3'b010, rd, 7'h73));
  endtask

  task automatic ebreak();
    put(32'h0010_0073);
  endtask

  task automatic begin_prog(input string name);
    test_name = name;
    wp = 0;
    n_ret = 0;
    n_mem = 0;
    x = '{default: '0};
    shmem.delete();
    dmem.delete();
    // unused words are lui x0 tagged with their own index
    for (int i = 0; i < 256; i++) begin
      imem[i[7:0]] = {12'(i), 13'd0, 7'h37};
    end
  endtask

  task automatic check_fetch();
    xlen_t pc_exp;
    if (fetch_q.size() == 0) begin
      stop_with_error($sformatf("%s fetched %h after the program ended", test_name, imem_addr));
    end else begin
      pc_exp = fetch_q.pop_front();
      assert (imem_addr == pc_exp) else stop_with_error($sformatf(
        "mismatch %s fetch: expected %h, actual %h", test_name, pc_exp, imem_addr));
    end
  endtask

  task automatic check_store();
    xlen_t a;
    xlen_t d;
    if (exp_addr.size() == 0) begin
      stop_with_error($sformatf("%s stored to %h with no store left", test_name, dmem_addr));
    end else begin
      a = exp_addr.pop_front();
      d = exp_data.pop_front();
      assert (dmem_addr == a) else stop_with_error($sformatf(
        "mismatch %s store address: expected %h, actual %h", test_name, a, dmem_addr));
      assert (dmem_wdata == d) else stop_with_error($sformatf(
        "mismatch %s store data: expected %h, actual %h", test_name, d, dmem_wdata));
    end
    dmem[dmem_addr] = dmem_wdata;
  endtask

  // memories answer one cycle after their strobe, driven on the falling edge
  always @(negedge clk) begin
    if (rst) begin
      imem_pend = 1'b0;
      dmem_pend = 1'b0;
    end else begin
      if (imem_pend) begin
        imem_rdata = imem[imem_idx];
      end
      if (dmem_pend) begin
        dmem_rdata = dmem.exists(dmem_raddr) ? dmem[dmem_raddr] : fill_word(dmem_raddr);
      end
      imem_pend = imem_en;
      dmem_pend = dmem_ren;
      dmem_raddr = dmem_addr;
      if (imem_en) begin
        check_fetch();
        imem_idx = 8'((imem_addr - reset_pc) >> 2);
      end
      if (dmem_wen) begin
        check_store();
      end
    end
  end

  // reset, run to ebreak, then watch the halted core stay quiet
  task automatic run_prog();
    limit += 5 * wp;
    rst = 1'b1;
    repeat (10) begin
      @(negedge clk);
      assert (!imem_en && !dmem_ren && !dmem_wen && !halted)
        else stop_with_error("a strobe or halted is high during reset");
    end
    rst = 1'b0;
    // first fetch goes out one cycle after release, from reset_pc
    @(negedge clk);
    assert (imem_en && imem_addr == reset_pc && !dmem_ren && !dmem_wen && !halted)
      else stop_with_error("first fetch is not at reset_pc on the cycle after reset");
    while (!halted) begin
      @(negedge clk);
    end
    repeat (20) begin
      @(negedge clk);
      assert (halted && !imem_en) else stop_with_error("core left halt after ebreak");
    end
    assert (fetch_q.size() == 0 && exp_addr.size() == 0)
      else stop_with_error($sformatf("%s halted before all its stores were seen", test_name));
  endtask

  initial begin
    int off [4];

    // lui, auipc, addi, add and shifts with random immediates
    begin_prog("arith");
    addi(10, 0, 1024);
    lui(1, rand_field(20));
    auipc(2, rand_field(20));
    addi(3, 1, rand_imm12());
    addi(4, 2, rand_imm12());
    add(5, 3, 4);
    slli(6, 5, rand_field(6));
    srli(7, 5, rand_field(6));
    addi(8, 0, rand_imm12());
    for (int r = 1; r <= 8; r++) begin
      sd(r, 10, 8 * r);
    end
    ebreak();
    run_prog();

    // taken and not taken beq, jal and jalr, links stored afterwards
    begin_prog("branch");
    addi(10, 0, 1024);
    addi(1, 0, 5);
    addi(2, 0, 5);
    beq(1, 2, 8);
    skip_word(enc_i(1, 0, 3'b000, 3, 7'h13));
    beq(1, 0, 8);
    jal(5, 8);
    skip_word(enc_i(2, 0, 3'b000, 3, 7'h13));
    auipc(6, 0);
    // odd offset, jalr drops bit 0 and lands two words on
    jalr(7, 6, 13);
    skip_word(enc_i(3, 0, 3'b000, 3, 7'h13));
    sd(5, 10, 0);
    sd(7, 10, 8);
    sd(6, 10, 16);
    sd(3, 10, 24);
    ebreak();
    run_prog();

    // sd to random aligned slots, ld back into other registers, store again
    begin_prog("ldsd");
    addi(10, 0, 8 * rand_field(8));
    addi(13, 10, 1024);
    for (int k = 0; k < 4; k++) begin
      off[k] = 64 * k + 8 * rand_field(3);
      lui(k + 1, rand_field(20));
      addi(k + 1, k + 1, rand_imm12());
      sd(k + 1, 10, off[k]);
    end
    for (int k = 0; k < 4; k++) begin
      ld(k + 20, 10, off[k]);
    end
    for (int k = 0; k < 4; k++) begin
      sd(k + 20, 13, 8 * k);
    end
    ebreak();
    run_prog();

    // minstret and mcycle reads with memory ops mixed in
    begin_prog("counters");
    addi(10, 0, 512);
    addi(1, 0, rand_imm12());
    sd(1, 10, 0);
    ld(2, 10, 0);
    csrr(5, 'hB02);
    csrr(6, 'hB00);
    addi(3, 0, 1);
    csrr(7, 'hB00);
    ld(4, 10, 0);
    csrr(8, 'hB02);
    sd(5, 10, 8);
    sd(6, 10, 16);
    sd(7, 10, 24);
    sd(8, 10, 32);
    ebreak();
    run_prog();

    $display("** PASS **");
    $finish;
  end

endmodule
